// File: list.f
+incdir+test
hdl/rv_decode_pkg.sv
hdl/rv_opcode_class.sv
hdl/rv_operand_extract.sv
hdl/rv_alu_op_decode.sv
hdl/rv_ctrl_decode.sv
hdl/rv_decode_reg.sv
hdl/rv_decode_top.sv
test/tb_rv_decode.sv

// File: test/tb_rv_decode_ref.svh
`ifndef TB_RV_DECODE_REF_SVH
`define TB_RV_DECODE_REF_SVH

function automatic rv_decode_pkg::class_t ref_class(input rv_decode_pkg::inst_t inst);
  case (inst[6:0])
    7'h37:   return rv_decode_pkg::CLASS_LUI;
    7'h17:   return rv_decode_pkg::CLASS_AUIPC;
    7'h6f:   return rv_decode_pkg::CLASS_JAL;
    7'h67:   return rv_decode_pkg::CLASS_JALR;
    7'h63:   return rv_decode_pkg::CLASS_BRANCH;
    7'h03:   return rv_decode_pkg::CLASS_LOAD;
    7'h23:   return rv_decode_pkg::CLASS_STORE;
    7'h13:   return rv_decode_pkg::CLASS_OP_IMM;
    7'h1b:   return rv_decode_pkg::CLASS_OP_IMM_32;
    7'h33:   return rv_decode_pkg::CLASS_OP;
    7'h3b:   return rv_decode_pkg::CLASS_OP_32;
    7'h73:   return rv_decode_pkg::CLASS_SYSTEM;
    default: return rv_decode_pkg::CLASS_NONE;
  endcase
endfunction

function automatic rv_decode_pkg::fmt_t ref_fmt(input rv_decode_pkg::inst_t inst);
  rv_decode_pkg::class_t c;
  c = ref_class(inst);
  if (c == rv_decode_pkg::CLASS_OP || c == rv_decode_pkg::CLASS_OP_32) return rv_decode_pkg::FMT_R;
  if (c == rv_decode_pkg::CLASS_LOAD || c == rv_decode_pkg::CLASS_OP_IMM ||
      c == rv_decode_pkg::CLASS_OP_IMM_32 || c == rv_decode_pkg::CLASS_JALR) begin
    return rv_decode_pkg::FMT_I;
  end
  if (c == rv_decode_pkg::CLASS_STORE) return rv_decode_pkg::FMT_S;
  if (c == rv_decode_pkg::CLASS_BRANCH) return rv_decode_pkg::FMT_B;
  if (c == rv_decode_pkg::CLASS_LUI || c == rv_decode_pkg::CLASS_AUIPC) return rv_decode_pkg::FMT_U;
  if (c == rv_decode_pkg::CLASS_JAL) return rv_decode_pkg::FMT_J;
  return rv_decode_pkg::FMT_NONE;
endfunction

// gated indices, one bit per format in the order none r i s b u j
function automatic rv_decode_pkg::reg_idx_t ref_idx(input rv_decode_pkg::inst_t inst,
                                                    input int lsb, input logic [6:0] used);
  if (used[ref_fmt(inst)]) return inst[lsb +: 5];
  return 5'd0;
endfunction

function automatic logic [63:0] ref_imm(input rv_decode_pkg::inst_t inst);
  case (ref_fmt(inst))
    rv_decode_pkg::FMT_I: return {{52{inst[31]}}, inst[31:20]};
    rv_decode_pkg::FMT_S: return {{52{inst[31]}}, inst[31:25], inst[11:7]};
    rv_decode_pkg::FMT_B: return {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    rv_decode_pkg::FMT_U: return {{32{inst[31]}}, inst[31:12], 12'h000};
    rv_decode_pkg::FMT_J: return {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    default:              return 64'd0;
  endcase
endfunction

function automatic rv_decode_pkg::alu_op_t ref_alu(input rv_decode_pkg::inst_t inst);
  rv_decode_pkg::alu_op_t reg_tab [8];
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = inst[14:12];
  f7 = inst[31:25];
  reg_tab = '{rv_decode_pkg::ALUOP_ADD, rv_decode_pkg::ALUOP_SLL, rv_decode_pkg::ALUOP_SLT,
              rv_decode_pkg::ALUOP_SLTU, rv_decode_pkg::ALUOP_XOR, rv_decode_pkg::ALUOP_SRL,
              rv_decode_pkg::ALUOP_OR, rv_decode_pkg::ALUOP_AND};
  case (ref_class(inst))
    rv_decode_pkg::CLASS_AUIPC, rv_decode_pkg::CLASS_JAL,
    rv_decode_pkg::CLASS_LOAD, rv_decode_pkg::CLASS_STORE: return rv_decode_pkg::ALUOP_ADD;
    rv_decode_pkg::CLASS_JALR: return (f3 == 0) ? rv_decode_pkg::ALUOP_ADD : rv_decode_pkg::ALUOP_NONE;
    rv_decode_pkg::CLASS_BRANCH: begin
      if (f3 == 2 || f3 == 3) return rv_decode_pkg::ALUOP_NONE;
      return rv_decode_pkg::ALUOP_BEQ + ((f3 < 2) ? f3 : f3 - 2);
    end
    rv_decode_pkg::CLASS_OP_IMM: begin
      // shifts keep a 6-bit shamt, so only bits 31:26 matter
      if (f3 == 1) return (f7[6:1] == 0) ? rv_decode_pkg::ALUOP_SLL : rv_decode_pkg::ALUOP_NONE;
      if (f3 == 5 && f7[6:1] == 6'b010000) return rv_decode_pkg::ALUOP_SRA;
      if (f3 == 5 && f7[6:1] != 0) return rv_decode_pkg::ALUOP_NONE;
      return reg_tab[f3];
    end
    rv_decode_pkg::CLASS_OP, rv_decode_pkg::CLASS_OP_IMM_32, rv_decode_pkg::CLASS_OP_32: begin
      if (ref_class(inst) == rv_decode_pkg::CLASS_OP_IMM_32 && f3 == 0) return rv_decode_pkg::ALUOP_ADD;
      if (ref_class(inst) != rv_decode_pkg::CLASS_OP && !(f3 == 0 || f3 == 1 || f3 == 5)) begin
        return rv_decode_pkg::ALUOP_NONE;
      end
      if (f7 == 7'h00) return reg_tab[f3];
      if (f7 == 7'h20 && f3 == 0 && ref_class(inst) != rv_decode_pkg::CLASS_OP_IMM_32) begin
        return rv_decode_pkg::ALUOP_SUB;
      end
      if (f7 == 7'h20 && f3 == 5) return rv_decode_pkg::ALUOP_SRA;
      return rv_decode_pkg::ALUOP_NONE;
    end
    default: return rv_decode_pkg::ALUOP_NONE;
  endcase
endfunction

function automatic rv_decode_pkg::mem_op_t ref_mem(input rv_decode_pkg::inst_t inst);
  if (ref_class(inst) == rv_decode_pkg::CLASS_LOAD && inst[14:12] != 3'd7) begin
    return rv_decode_pkg::MEMOP_LB + inst[14:12];
  end
  if (ref_class(inst) == rv_decode_pkg::CLASS_STORE && inst[14] == 1'b0) begin
    return rv_decode_pkg::MEMOP_SB + inst[13:12];
  end
  return rv_decode_pkg::MEMOP_NONE;
endfunction

function automatic rv_decode_pkg::exc_op_t ref_exc(input rv_decode_pkg::inst_t inst);
  rv_decode_pkg::class_t c;
  c = ref_class(inst);
  if (c == rv_decode_pkg::CLASS_SYSTEM) begin
    if (inst[14:12] == 0 && inst[31:20] == 12'h001) return rv_decode_pkg::EXCOP_EBREAK;
    return rv_decode_pkg::EXCOP_NONE;
  end
  // execute codes 1 to 11 line up with the class codes
  return rv_decode_pkg::exc_op_t'(c);
endfunction

function automatic rv_decode_pkg::pc_op_t ref_pc(input rv_decode_pkg::inst_t inst);
  case (ref_class(inst))
    rv_decode_pkg::CLASS_BRANCH: return rv_decode_pkg::PCOP_BRANCH;
    rv_decode_pkg::CLASS_JAL:    return rv_decode_pkg::PCOP_JAL;
    rv_decode_pkg::CLASS_JALR:   return (inst[14:12] == 0) ? rv_decode_pkg::PCOP_JALR : rv_decode_pkg::PCOP_INC4;
    default:                     return rv_decode_pkg::PCOP_INC4;
  endcase
endfunction

// mode 1 and 2 pin funct7, mode 3 builds an ebreak pattern
function automatic rv_decode_pkg::inst_t build_inst(input logic [6:0] opcode,
                                                    input logic [31:0] raw, input logic [1:0] mode);
  case (mode)
    2'd1:    return {7'b0000000, raw[24:7], opcode};
    2'd2:    return {7'b0100000, raw[24:7], opcode};
    2'd3:    return {12'h001, raw[19:15], 3'b000, raw[11:7], opcode};
    default: return {raw[31:7], opcode};
  endcase
endfunction

`endif

// File: test/tb_rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode;

  localparam int NUM_DRAWS      = 2000;
  localparam int RESET_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = NUM_DRAWS + RESET_CYCLES + 100;

  logic clk;
  logic rst_n;
  logic inst_valid;
  rv_decode_pkg::inst_t inst_data;

  logic out_valid;
  rv_decode_pkg::reg_idx_t rs1_idx;
  rv_decode_pkg::reg_idx_t rs2_idx;
  rv_decode_pkg::reg_idx_t rd_idx;
  logic [63:0] imm_data;
  rv_decode_pkg::alu_op_t alu_op;
  rv_decode_pkg::mem_op_t mem_op;
  rv_decode_pkg::exc_op_t exc_op;
  rv_decode_pkg::pc_op_t pc_op;

  // expected outputs lag the stimulus by one cycle like the DUT
  logic exp_valid;
  rv_decode_pkg::reg_idx_t exp_rs1;
  rv_decode_pkg::reg_idx_t exp_rs2;
  rv_decode_pkg::reg_idx_t exp_rd;
  logic [63:0] exp_imm;
  rv_decode_pkg::alu_op_t exp_alu;
  rv_decode_pkg::mem_op_t exp_mem;
  rv_decode_pkg::exc_op_t exp_exc;
  rv_decode_pkg::pc_op_t exp_pc;

  logic [31:0] lfsr_state;
  logic [6:0] opcode_tab [14];
  int error_count;
  int check_count;
  int sent_count;
  int cycle_count;

  `include "tb_rv_decode_ref.svh"

  rv_decode_top #(.XLEN(64)) dut_i (
    .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst_data(inst_data),
    .out_valid(out_valid), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx),
    .imm_data(imm_data), .alu_op(alu_op), .mem_op(mem_op), .exc_op(exc_op), .pc_op(pc_op)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    error_count++;
    $display("[FAIL] %s got %h expected %h at cycle %0d", name, got, exp, cycle_count);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_n || !inst_valid) begin
      exp_valid <= 1'b0;
      {exp_rs1, exp_rs2, exp_rd, exp_imm} <= '0;
      {exp_alu, exp_mem, exp_exc, exp_pc} <= '0;
    end else begin
      exp_valid <= 1'b1;
      exp_rs1   <= ref_idx(inst_data, 15, 7'b0011110);
      exp_rs2   <= ref_idx(inst_data, 20, 7'b0011010);
      exp_rd    <= ref_idx(inst_data, 7, 7'b1100110);
      exp_imm   <= ref_imm(inst_data);
      exp_alu   <= ref_alu(inst_data);
      exp_mem   <= ref_mem(inst_data);
      exp_exc   <= ref_exc(inst_data);
      exp_pc    <= ref_pc(inst_data);
    end
    if (rst_n && out_valid) check_count++;
  end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
    else report_mismatch("out_valid", $sampled(out_valid), $sampled(exp_valid));
  a_rs1: assert property (@(posedge clk) disable iff (!rst_n) rs1_idx == exp_rs1)
    else report_mismatch("rs1_idx", $sampled(rs1_idx), $sampled(exp_rs1));
  a_rs2: assert property (@(posedge clk) disable iff (!rst_n) rs2_idx == exp_rs2)
    else report_mismatch("rs2_idx", $sampled(rs2_idx), $sampled(exp_rs2));
  a_rd: assert property (@(posedge clk) disable iff (!rst_n) rd_idx == exp_rd)
    else report_mismatch("rd_idx", $sampled(rd_idx), $sampled(exp_rd));
  a_imm: assert property (@(posedge clk) disable iff (!rst_n) imm_data == exp_imm)
    else report_mismatch("imm_data", $sampled(imm_data), $sampled(exp_imm));
  a_alu: assert property (@(posedge clk) disable iff (!rst_n) alu_op == exp_alu)
    else report_mismatch("alu_op", $sampled(alu_op), $sampled(exp_alu));
  a_mem: assert property (@(posedge clk) disable iff (!rst_n) mem_op == exp_mem)
    else report_mismatch("mem_op", $sampled(mem_op), $sampled(exp_mem));
  a_exc: assert property (@(posedge clk) disable iff (!rst_n) exc_op == exp_exc)
    else report_mismatch("exc_op", $sampled(exc_op), $sampled(exp_exc));
  a_pc: assert property (@(posedge clk) disable iff (!rst_n) pc_op == exp_pc)
    else report_mismatch("pc_op", $sampled(pc_op), $sampled(exp_pc));

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [31:0] idx;
    logic [31:0] mode;
    logic [31:0] raw;
    logic [31:0] vbit;
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst_data = '0;
    lfsr_state = 32'he636b636;
    error_count = 0;
    check_count = 0;
    sent_count = 0;
    cycle_count = 0;
    // eleven kept opcodes followed by system, fence and op-fp
    opcode_tab = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h1b, 7'h33,
                   7'h3b, 7'h73, 7'h0f, 7'h53};
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // outputs must stay zero in the idle window after reset
    repeat (3) @(posedge clk);
    for (int i = 0; i < NUM_DRAWS; i++) begin
      idx = take_bits(4);
      if (idx >= 14) idx = idx - 14;
      mode = take_bits(2);
      raw = take_bits(32);
      vbit = take_bits(2);
      inst_data <= build_inst(opcode_tab[idx], raw, mode[1:0]);
      inst_valid <= (vbit != 0);
      if (vbit != 0) sent_count++;
      @(posedge clk);
    end
    inst_valid <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (check_count == 0) begin
      error_count++;
      $display("no valid output was ever seen from the DUT");
    end
    $display("instructions=%0d checked=%0d errors=%0d", sent_count, check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top #(
  parameter int XLEN = 64
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       inst_valid,
  input  wire rv_decode_pkg::inst_t inst_data,
  output logic                      out_valid,
  output rv_decode_pkg::reg_idx_t   rs1_idx,
  output rv_decode_pkg::reg_idx_t   rs2_idx,
  output rv_decode_pkg::reg_idx_t   rd_idx,
  output logic [XLEN-1:0]           imm_data,
  output rv_decode_pkg::alu_op_t    alu_op,
  output rv_decode_pkg::mem_op_t    mem_op,
  output rv_decode_pkg::exc_op_t    exc_op,
  output rv_decode_pkg::pc_op_t     pc_op
);

  rv_decode_pkg::class_t   inst_class;
  rv_decode_pkg::fmt_t     fmt;
  // combinational decode results, ahead of the register
  rv_decode_pkg::reg_idx_t rs1_idx_d;
  rv_decode_pkg::reg_idx_t rs2_idx_d;
  rv_decode_pkg::reg_idx_t rd_idx_d;
  logic [XLEN-1:0]         imm_data_d;
  rv_decode_pkg::alu_op_t  alu_op_d;
  rv_decode_pkg::mem_op_t  mem_op_d;
  rv_decode_pkg::exc_op_t  exc_op_d;
  rv_decode_pkg::pc_op_t   pc_op_d;

  rv_opcode_class u_class (
    .inst_data  (inst_data),
    .inst_class (inst_class),
    .fmt        (fmt)
  );

  rv_operand_extract #(.XLEN(XLEN)) u_operand (
    .inst_data (inst_data),
    .fmt       (fmt),
    .rs1_idx   (rs1_idx_d),
    .rs2_idx   (rs2_idx_d),
    .rd_idx    (rd_idx_d),
    .imm_data  (imm_data_d)
  );

  rv_alu_op_decode u_alu (
    .inst_data  (inst_data),
    .inst_class (inst_class),
    .alu_op     (alu_op_d)
  );

  rv_ctrl_decode u_ctrl (
    .inst_data  (inst_data),
    .inst_class (inst_class),
    .mem_op     (mem_op_d),
    .exc_op     (exc_op_d),
    .pc_op      (pc_op_d)
  );

  // single pipeline stage on the way out
  rv_decode_reg #(.XLEN(XLEN)) u_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .rs1_idx    (rs1_idx_d),
    .rs2_idx    (rs2_idx_d),
    .rd_idx     (rd_idx_d),
    .imm_data   (imm_data_d),
    .alu_op     (alu_op_d),
    .mem_op     (mem_op_d),
    .exc_op     (exc_op_d),
    .pc_op      (pc_op_d),
    .out_valid  (out_valid),
    .rs1_idx_q  (rs1_idx),
    .rs2_idx_q  (rs2_idx),
    .rd_idx_q   (rd_idx),
    .imm_data_q (imm_data),
    .alu_op_q   (alu_op),
    .mem_op_q   (mem_op),
    .exc_op_q   (exc_op),
    .pc_op_q    (pc_op)
  );

endmodule

`default_nettype wire

// File: hdl/rv_decode_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_reg #(
  parameter int XLEN = 64
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          inst_valid,
  input  wire rv_decode_pkg::reg_idx_t rs1_idx,
  input  wire rv_decode_pkg::reg_idx_t rs2_idx,
  input  wire rv_decode_pkg::reg_idx_t rd_idx,
  input  wire [XLEN-1:0]               imm_data,
  input  wire rv_decode_pkg::alu_op_t  alu_op,
  input  wire rv_decode_pkg::mem_op_t  mem_op,
  input  wire rv_decode_pkg::exc_op_t  exc_op,
  input  wire rv_decode_pkg::pc_op_t   pc_op,
  output logic                         out_valid,
  output rv_decode_pkg::reg_idx_t      rs1_idx_q,
  output rv_decode_pkg::reg_idx_t      rs2_idx_q,
  output rv_decode_pkg::reg_idx_t      rd_idx_q,
  output logic [XLEN-1:0]              imm_data_q,
  output rv_decode_pkg::alu_op_t       alu_op_q,
  output rv_decode_pkg::mem_op_t       mem_op_q,
  output rv_decode_pkg::exc_op_t       exc_op_q,
  output rv_decode_pkg::pc_op_t        pc_op_q
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= inst_valid;
    end
  end

  // idle cycles leave every field at zero
  always_ff @(posedge clk) begin
    if (!rst_n || !inst_valid) begin
      rs1_idx_q  <= '0;
      rs2_idx_q  <= '0;
      rd_idx_q   <= '0;
      imm_data_q <= '0;
      alu_op_q   <= rv_decode_pkg::ALUOP_NONE;
      mem_op_q   <= rv_decode_pkg::MEMOP_NONE;
      exc_op_q   <= rv_decode_pkg::EXCOP_NONE;
      pc_op_q    <= rv_decode_pkg::PCOP_INC4;
    end else begin
      rs1_idx_q  <= rs1_idx;
      rs2_idx_q  <= rs2_idx;
      rd_idx_q   <= rd_idx;
      imm_data_q <= imm_data;
      alu_op_q   <= alu_op;
      mem_op_q   <= mem_op;
      exc_op_q   <= exc_op;
      pc_op_q    <= pc_op;
    end
  end

  a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid |-> (rs1_idx_q == '0 && rs2_idx_q == '0 && rd_idx_q == '0 &&
                    imm_data_q == '0 && alu_op_q == '0 && mem_op_q == '0 &&
                    exc_op_q == '0 && pc_op_q == '0));

  // memory code and execute class come from separate slices
  a_mem_is_ldst: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_op_q != rv_decode_pkg::MEMOP_NONE) |->
      (exc_op_q == rv_decode_pkg::EXCOP_LOAD || exc_op_q == rv_decode_pkg::EXCOP_STORE));

  // a branch with an undefined func3 still steers the pc but gets no compare
  a_branch_cmp: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_op_q == rv_decode_pkg::PCOP_BRANCH) |->
      (alu_op_q == rv_decode_pkg::ALUOP_NONE ||
       (alu_op_q >= rv_decode_pkg::ALUOP_BEQ && alu_op_q <= rv_decode_pkg::ALUOP_BGEU)));

endmodule

`default_nettype wire

// File: hdl/rv_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_decode (
  input  wire rv_decode_pkg::inst_t  inst_data,
  input  wire rv_decode_pkg::class_t inst_class,
  output rv_decode_pkg::mem_op_t     mem_op,
  output rv_decode_pkg::exc_op_t     exc_op,
  output rv_decode_pkg::pc_op_t      pc_op
);

  logic [2:0] func3;
  logic       is_ebreak;

  assign func3     = inst_data[14:12];
  assign is_ebreak = (inst_class == rv_decode_pkg::CLASS_SYSTEM) && (func3 == 3'd0) &&
                     (inst_data[31:20] == 12'd1);

  // access width and sign from func3
  always_comb begin
    mem_op = rv_decode_pkg::MEMOP_NONE;
    if (inst_class == rv_decode_pkg::CLASS_LOAD) begin
      case (func3)
        3'd0:    mem_op = rv_decode_pkg::MEMOP_LB;
        3'd1:    mem_op = rv_decode_pkg::MEMOP_LH;
        3'd2:    mem_op = rv_decode_pkg::MEMOP_LW;
        3'd3:    mem_op = rv_decode_pkg::MEMOP_LD;
        3'd4:    mem_op = rv_decode_pkg::MEMOP_LBU;
        3'd5:    mem_op = rv_decode_pkg::MEMOP_LHU;
        3'd6:    mem_op = rv_decode_pkg::MEMOP_LWU;
        default: mem_op = rv_decode_pkg::MEMOP_NONE;
      endcase
    end else if (inst_class == rv_decode_pkg::CLASS_STORE) begin
      case (func3)
        3'd0:    mem_op = rv_decode_pkg::MEMOP_SB;
        3'd1:    mem_op = rv_decode_pkg::MEMOP_SH;
        3'd2:    mem_op = rv_decode_pkg::MEMOP_SW;
        3'd3:    mem_op = rv_decode_pkg::MEMOP_SD;
        default: mem_op = rv_decode_pkg::MEMOP_NONE;
      endcase
    end
  end

  always_comb begin
    case (inst_class)
      rv_decode_pkg::CLASS_LUI:       exc_op = rv_decode_pkg::EXCOP_LUI;
      rv_decode_pkg::CLASS_AUIPC:     exc_op = rv_decode_pkg::EXCOP_AUIPC;
      rv_decode_pkg::CLASS_JAL:       exc_op = rv_decode_pkg::EXCOP_JAL;
      rv_decode_pkg::CLASS_JALR:      exc_op = rv_decode_pkg::EXCOP_JALR;
      rv_decode_pkg::CLASS_BRANCH:    exc_op = rv_decode_pkg::EXCOP_BRANCH;
      rv_decode_pkg::CLASS_LOAD:      exc_op = rv_decode_pkg::EXCOP_LOAD;
      rv_decode_pkg::CLASS_STORE:     exc_op = rv_decode_pkg::EXCOP_STORE;
      rv_decode_pkg::CLASS_OP_IMM:    exc_op = rv_decode_pkg::EXCOP_OPIMM;
      rv_decode_pkg::CLASS_OP_IMM_32: exc_op = rv_decode_pkg::EXCOP_OPIMM32;
      rv_decode_pkg::CLASS_OP:        exc_op = rv_decode_pkg::EXCOP_OP;
      rv_decode_pkg::CLASS_OP_32:     exc_op = rv_decode_pkg::EXCOP_OP32;
      // ecall and csr ops are not decoded
      default: exc_op = is_ebreak ? rv_decode_pkg::EXCOP_EBREAK : rv_decode_pkg::EXCOP_NONE;
    endcase
  end

  // branch first, then jal, then jalr
  always_comb begin
    if (inst_class == rv_decode_pkg::CLASS_BRANCH) begin
      pc_op = rv_decode_pkg::PCOP_BRANCH;
    end else if (inst_class == rv_decode_pkg::CLASS_JAL) begin
      pc_op = rv_decode_pkg::PCOP_JAL;
    end else if (inst_class == rv_decode_pkg::CLASS_JALR && func3 == 3'd0) begin
      pc_op = rv_decode_pkg::PCOP_JALR;
    end else begin
      pc_op = rv_decode_pkg::PCOP_INC4;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_alu_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_op_decode (
  input  wire rv_decode_pkg::inst_t  inst_data,
  input  wire rv_decode_pkg::class_t inst_class,
  output rv_decode_pkg::alu_op_t     alu_op
);

  logic [2:0] func3;
  logic       f7_zero;
  logic       f7_alt;
  logic       f6_zero;
  logic       f6_alt;

  assign func3   = inst_data[14:12];
  assign f7_zero = (inst_data[31:25] == 7'b0000000);
  assign f7_alt  = (inst_data[31:25] == 7'b0100000);
  // rv64 op_imm shifts use a 6-bit shamt, so only funct6 is fixed
  assign f6_zero = (inst_data[31:26] == 6'b000000);
  assign f6_alt  = (inst_data[31:26] == 6'b010000);

  always_comb begin
    alu_op = rv_decode_pkg::ALUOP_NONE;
    case (inst_class)
      rv_decode_pkg::CLASS_AUIPC,
      rv_decode_pkg::CLASS_JAL,
      rv_decode_pkg::CLASS_LOAD,
      rv_decode_pkg::CLASS_STORE: alu_op = rv_decode_pkg::ALUOP_ADD;
      rv_decode_pkg::CLASS_JALR: begin
        if (func3 == 3'd0) alu_op = rv_decode_pkg::ALUOP_ADD;
      end
      rv_decode_pkg::CLASS_BRANCH: begin
        case (func3)
          3'd0:    alu_op = rv_decode_pkg::ALUOP_BEQ;
          3'd1:    alu_op = rv_decode_pkg::ALUOP_BNE;
          3'd4:    alu_op = rv_decode_pkg::ALUOP_BLT;
          3'd5:    alu_op = rv_decode_pkg::ALUOP_BGE;
          3'd6:    alu_op = rv_decode_pkg::ALUOP_BLTU;
          3'd7:    alu_op = rv_decode_pkg::ALUOP_BGEU;
          default: alu_op = rv_decode_pkg::ALUOP_NONE;
        endcase
      end
      rv_decode_pkg::CLASS_OP_IMM: begin
        case (func3)
          3'd0: alu_op = rv_decode_pkg::ALUOP_ADD;
          3'd1: if (f6_zero) alu_op = rv_decode_pkg::ALUOP_SLL;
          3'd2: alu_op = rv_decode_pkg::ALUOP_SLT;
          3'd3: alu_op = rv_decode_pkg::ALUOP_SLTU;
          3'd4: alu_op = rv_decode_pkg::ALUOP_XOR;
          3'd5: begin
            if (f6_zero) alu_op = rv_decode_pkg::ALUOP_SRL;
            else if (f6_alt) alu_op = rv_decode_pkg::ALUOP_SRA;
          end
          3'd6: alu_op = rv_decode_pkg::ALUOP_OR;
          3'd7: alu_op = rv_decode_pkg::ALUOP_AND;
        endcase
      end
      rv_decode_pkg::CLASS_OP_IMM_32: begin
        // addiw, slliw, srliw, sraiw
        if (func3 == 3'd0) alu_op = rv_decode_pkg::ALUOP_ADD;
        else if (func3 == 3'd1 && f7_zero) alu_op = rv_decode_pkg::ALUOP_SLL;
        else if (func3 == 3'd5 && f7_zero) alu_op = rv_decode_pkg::ALUOP_SRL;
        else if (func3 == 3'd5 && f7_alt) alu_op = rv_decode_pkg::ALUOP_SRA;
      end
      rv_decode_pkg::CLASS_OP: begin
        if (f7_zero) begin
          case (func3)
            3'd0: alu_op = rv_decode_pkg::ALUOP_ADD;
            3'd1: alu_op = rv_decode_pkg::ALUOP_SLL;
            3'd2: alu_op = rv_decode_pkg::ALUOP_SLT;
            3'd3: alu_op = rv_decode_pkg::ALUOP_SLTU;
            3'd4: alu_op = rv_decode_pkg::ALUOP_XOR;
            3'd5: alu_op = rv_decode_pkg::ALUOP_SRL;
            3'd6: alu_op = rv_decode_pkg::ALUOP_OR;
            3'd7: alu_op = rv_decode_pkg::ALUOP_AND;
          endcase
        end else if (f7_alt) begin
          if (func3 == 3'd0) alu_op = rv_decode_pkg::ALUOP_SUB;
          else if (func3 == 3'd5) alu_op = rv_decode_pkg::ALUOP_SRA;
        end
      end
      rv_decode_pkg::CLASS_OP_32: begin
        // only the W forms live here
        if (func3 == 3'd0 && f7_zero) alu_op = rv_decode_pkg::ALUOP_ADD;
        else if (func3 == 3'd0 && f7_alt) alu_op = rv_decode_pkg::ALUOP_SUB;
        else if (func3 == 3'd1 && f7_zero) alu_op = rv_decode_pkg::ALUOP_SLL;
        else if (func3 == 3'd5 && f7_zero) alu_op = rv_decode_pkg::ALUOP_SRL;
        else if (func3 == 3'd5 && f7_alt) alu_op = rv_decode_pkg::ALUOP_SRA;
      end
      default: alu_op = rv_decode_pkg::ALUOP_NONE;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_operand_extract.sv
`timescale 1ns/1ps
`default_nettype none

module rv_operand_extract #(
  parameter int XLEN = 64
) (
  input  wire rv_decode_pkg::inst_t inst_data,
  input  wire rv_decode_pkg::fmt_t  fmt,
  output rv_decode_pkg::reg_idx_t   rs1_idx,
  output rv_decode_pkg::reg_idx_t   rs2_idx,
  output rv_decode_pkg::reg_idx_t   rd_idx,
  output logic [XLEN-1:0]           imm_data
);

  // 32-bit signed layouts, widened to XLEN on assignment
  logic signed [31:0] imm_i;
  logic signed [31:0] imm_s;
  logic signed [31:0] imm_b;
  logic signed [31:0] imm_u;
  logic signed [31:0] imm_j;

  assign imm_i = {{20{inst_data[31]}}, inst_data[31:20]};
  assign imm_s = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
  assign imm_b = {{19{inst_data[31]}}, inst_data[31], inst_data[7],
                  inst_data[30:25], inst_data[11:8], 1'b0};
  assign imm_u = {inst_data[31:12], 12'b0};
  assign imm_j = {{11{inst_data[31]}}, inst_data[31], inst_data[19:12],
                  inst_data[20], inst_data[30:21], 1'b0};

  // index fields only where the format has them
  assign rs1_idx = (fmt == rv_decode_pkg::FMT_R || fmt == rv_decode_pkg::FMT_I ||
                    fmt == rv_decode_pkg::FMT_S || fmt == rv_decode_pkg::FMT_B) ?
                   inst_data[19:15] : 5'd0;
  assign rs2_idx = (fmt == rv_decode_pkg::FMT_R || fmt == rv_decode_pkg::FMT_S ||
                    fmt == rv_decode_pkg::FMT_B) ? inst_data[24:20] : 5'd0;
  assign rd_idx  = (fmt == rv_decode_pkg::FMT_R || fmt == rv_decode_pkg::FMT_I ||
                    fmt == rv_decode_pkg::FMT_U || fmt == rv_decode_pkg::FMT_J) ?
                   inst_data[11:7] : 5'd0;

  // signed source sign-extends into the wider target
  always_comb begin
    case (fmt)
      rv_decode_pkg::FMT_I: imm_data = imm_i;
      rv_decode_pkg::FMT_S: imm_data = imm_s;
      rv_decode_pkg::FMT_B: imm_data = imm_b;
      rv_decode_pkg::FMT_U: imm_data = imm_u;
      rv_decode_pkg::FMT_J: imm_data = imm_j;
      default:              imm_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_opcode_class.sv
`timescale 1ns/1ps
`default_nettype none

module rv_opcode_class (
  input  wire rv_decode_pkg::inst_t inst_data,
  output rv_decode_pkg::class_t     inst_class,
  output rv_decode_pkg::fmt_t       fmt
);

  // standard opcodes, low two bits always 11
  always_comb begin
    case (inst_data[6:0])
      7'b0110111: inst_class = rv_decode_pkg::CLASS_LUI;
      7'b0010111: inst_class = rv_decode_pkg::CLASS_AUIPC;
      7'b1101111: inst_class = rv_decode_pkg::CLASS_JAL;
      7'b1100111: inst_class = rv_decode_pkg::CLASS_JALR;
      7'b1100011: inst_class = rv_decode_pkg::CLASS_BRANCH;
      7'b0000011: inst_class = rv_decode_pkg::CLASS_LOAD;
      7'b0100011: inst_class = rv_decode_pkg::CLASS_STORE;
      7'b0010011: inst_class = rv_decode_pkg::CLASS_OP_IMM;
      7'b0011011: inst_class = rv_decode_pkg::CLASS_OP_IMM_32;
      7'b0110011: inst_class = rv_decode_pkg::CLASS_OP;
      7'b0111011: inst_class = rv_decode_pkg::CLASS_OP_32;
      7'b1110011: inst_class = rv_decode_pkg::CLASS_SYSTEM;
      // fence, fp, amo, custom and reserved all land here
      default:    inst_class = rv_decode_pkg::CLASS_NONE;
    endcase
  end

  // operand format per class
  always_comb begin
    case (inst_class)
      rv_decode_pkg::CLASS_OP,
      rv_decode_pkg::CLASS_OP_32:     fmt = rv_decode_pkg::FMT_R;
      rv_decode_pkg::CLASS_LOAD,
      rv_decode_pkg::CLASS_OP_IMM,
      rv_decode_pkg::CLASS_OP_IMM_32,
      rv_decode_pkg::CLASS_JALR:      fmt = rv_decode_pkg::FMT_I;
      rv_decode_pkg::CLASS_STORE:     fmt = rv_decode_pkg::FMT_S;
      rv_decode_pkg::CLASS_BRANCH:    fmt = rv_decode_pkg::FMT_B;
      rv_decode_pkg::CLASS_LUI,
      rv_decode_pkg::CLASS_AUIPC:     fmt = rv_decode_pkg::FMT_U;
      rv_decode_pkg::CLASS_JAL:       fmt = rv_decode_pkg::FMT_J;
      default:                        fmt = rv_decode_pkg::FMT_NONE;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

  // instruction word and register index
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // decode result codes
  typedef logic [3:0] class_t;
  typedef logic [2:0] fmt_t;
  typedef logic [4:0] alu_op_t;
  typedef logic [3:0] mem_op_t;
  typedef logic [3:0] exc_op_t;
  typedef logic [1:0] pc_op_t;

  // instruction classes, one per kept opcode
  localparam class_t CLASS_NONE      = 4'd0;
  localparam class_t CLASS_LUI       = 4'd1;
  localparam class_t CLASS_AUIPC     = 4'd2;
  localparam class_t CLASS_JAL       = 4'd3;
  localparam class_t CLASS_JALR      = 4'd4;
  localparam class_t CLASS_BRANCH    = 4'd5;
  localparam class_t CLASS_LOAD      = 4'd6;
  localparam class_t CLASS_STORE     = 4'd7;
  localparam class_t CLASS_OP_IMM    = 4'd8;
  localparam class_t CLASS_OP_IMM_32 = 4'd9;
  localparam class_t CLASS_OP        = 4'd10;
  localparam class_t CLASS_OP_32     = 4'd11;
  localparam class_t CLASS_SYSTEM    = 4'd12;

  // operand formats
  localparam fmt_t FMT_NONE = 3'd0;
  localparam fmt_t FMT_R    = 3'd1;
  localparam fmt_t FMT_I    = 3'd2;
  localparam fmt_t FMT_S    = 3'd3;
  localparam fmt_t FMT_B    = 3'd4;
  localparam fmt_t FMT_U    = 3'd5;
  localparam fmt_t FMT_J    = 3'd6;

  localparam alu_op_t ALUOP_NONE = 5'd0;
  localparam alu_op_t ALUOP_ADD  = 5'd1;
  localparam alu_op_t ALUOP_SUB  = 5'd2;
  localparam alu_op_t ALUOP_XOR  = 5'd3;
  localparam alu_op_t ALUOP_AND  = 5'd4;
  localparam alu_op_t ALUOP_OR   = 5'd5;
  localparam alu_op_t ALUOP_SLL  = 5'd6;
  localparam alu_op_t ALUOP_SRL  = 5'd7;
  localparam alu_op_t ALUOP_SRA  = 5'd8;
  localparam alu_op_t ALUOP_SLT  = 5'd9;
  localparam alu_op_t ALUOP_SLTU = 5'd10;
  // branch compares, kept contiguous
  localparam alu_op_t ALUOP_BEQ  = 5'd11;
  localparam alu_op_t ALUOP_BNE  = 5'd12;
  localparam alu_op_t ALUOP_BLT  = 5'd13;
  localparam alu_op_t ALUOP_BGE  = 5'd14;
  localparam alu_op_t ALUOP_BLTU = 5'd15;
  localparam alu_op_t ALUOP_BGEU = 5'd16;

  localparam mem_op_t MEMOP_NONE = 4'd0;
  localparam mem_op_t MEMOP_LB   = 4'd1;
  localparam mem_op_t MEMOP_LH   = 4'd2;
  localparam mem_op_t MEMOP_LW   = 4'd3;
  localparam mem_op_t MEMOP_LD   = 4'd4;
  localparam mem_op_t MEMOP_LBU  = 4'd5;
  localparam mem_op_t MEMOP_LHU  = 4'd6;
  localparam mem_op_t MEMOP_LWU  = 4'd7;
  localparam mem_op_t MEMOP_SB   = 4'd8;
  localparam mem_op_t MEMOP_SH   = 4'd9;
  localparam mem_op_t MEMOP_SW   = 4'd10;
  localparam mem_op_t MEMOP_SD   = 4'd11;

  localparam exc_op_t EXCOP_NONE    = 4'd0;
  localparam exc_op_t EXCOP_LUI     = 4'd1;
  localparam exc_op_t EXCOP_AUIPC   = 4'd2;
  localparam exc_op_t EXCOP_JAL     = 4'd3;
  localparam exc_op_t EXCOP_JALR    = 4'd4;
  localparam exc_op_t EXCOP_BRANCH  = 4'd5;
  localparam exc_op_t EXCOP_LOAD    = 4'd6;
  localparam exc_op_t EXCOP_STORE   = 4'd7;
  localparam exc_op_t EXCOP_OPIMM   = 4'd8;
  localparam exc_op_t EXCOP_OPIMM32 = 4'd9;
  localparam exc_op_t EXCOP_OP      = 4'd10;
  localparam exc_op_t EXCOP_OP32    = 4'd11;
  localparam exc_op_t EXCOP_EBREAK  = 4'd12;

  localparam pc_op_t PCOP_INC4   = 2'd0;
  localparam pc_op_t PCOP_BRANCH = 2'd1;
  localparam pc_op_t PCOP_JAL    = 2'd2;
  localparam pc_op_t PCOP_JALR   = 2'd3;

endpackage

`default_nettype wire
